//--- rvIsaPkg.sv
`default_nettype none

// instruction set definitions for the rv32i fetch slice
// only what fetch and branch resolution look at
package rvIsaPkg;

    // one instruction, byte address or operand value
    typedef logic [31:0] wordT;

    // byte size of an instruction word, also the sequential pc step
    localparam int wordBytes = 4;

    // opcode field
    localparam int opcodeLsb = 0;
    localparam int opcodeMsb = 6;

    // func3 field, selects the branch comparison
    localparam int func3Lsb = 12;
    localparam int func3Msb = 14;

    // every immediate takes its sign from the top instruction bit
    localparam int signBit = 31;

    // major opcodes of rv32i
    // anything not listed here is fetched as a plain instruction
    typedef enum logic [6:0] {
        opLoad   = 7'b0000011,
        opOpImm  = 7'b0010011,
        opAuipc  = 7'b0010111,
        opStore  = 7'b0100011,
        opOp     = 7'b0110011,
        opLui    = 7'b0110111,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111,
        opJal    = 7'b1101111
    } opcodeT;

    // func3 of the branch opcode
    // codes 010 and 011 are unused and never branch
    typedef enum logic [2:0] {
        funcBeq  = 3'b000,
        funcBne  = 3'b001,
        funcBlt  = 3'b100,
        funcBge  = 3'b101,
        funcBltu = 3'b110,
        funcBgeu = 3'b111
    } branchFunctT;

endpackage

`default_nettype wire

//--- fetchPkg.sv
`default_nettype none

// definitions private to the fetch and branch slice
package fetchPkg;

    // bit positions in the comparator flag vector
    // order follows the program counter's view of the flags
    localparam int eqFlag   = 6;
    localparam int neFlag   = 5;
    localparam int ltuFlag  = 4;
    localparam int ltFlag   = 3;
    localparam int geuFlag  = 2;
    localparam int geFlag   = 1;
    // operand a is zero, informational only
    localparam int zeroFlag = 0;

    // number of flags, sizes the vector below
    localparam int flagCount = 7;

    // comparator result vector
    typedef logic [flagCount-1:0] flagsT;

    // what kind of control transfer the fetched word asks for
    // jumpForce is unconditional (jal)
    // jumpCond waits on the comparator flags
    typedef enum logic [1:0] {
        jumpNone  = 2'd0,
        jumpForce = 2'd1,
        jumpCond  = 2'd2
    } jumpKindT;

endpackage

`default_nettype wire

//--- t07_instruction_memory.sv
`timescale 1ns/1ps
`default_nettype none

// instruction store for the fetch slice
// loaded by a plain write strobe and read combinationally at the pc
module t07_instruction_memory #(
    parameter int imemWords = 256
) (
    input  logic           clk,
    input  logic           loadEn,
    input  rvIsaPkg::wordT loadAddr,
    input  rvIsaPkg::wordT loadData,
    input  rvIsaPkg::wordT readAddr,
    output rvIsaPkg::wordT readData
);
    import rvIsaPkg::*;

    // index width is at least one bit even for a single-word memory
    localparam int idxBits = (imemWords > 1) ? $clog2(imemWords) : 1;

    // word storage
    wordT mem [imemWords];

    logic [idxBits-1:0] loadIdx;
    logic [idxBits-1:0] readIdx;

    // byte address to word index
    // the low two bits drop off and the index wraps at the memory depth
    assign loadIdx = idxBits'((loadAddr / wordBytes) % imemWords);
    assign readIdx = idxBits'((readAddr / wordBytes) % imemWords);

    // synchronous load port
    always_ff @(posedge clk) begin
        if (loadEn) begin
            mem[loadIdx] <= loadData;
        end
    end

    // asynchronous read where a load shows up the cycle after its edge
    assign readData = mem[readIdx];

    // the loader should never rely on the wrap, so flag any word past the end
    loadInRange: assert property (
        @(posedge clk) loadEn |-> ((loadAddr / wordBytes) < imemWords)
    ) else $error("instruction memory load beyond depth, addr %h", loadAddr);

endmodule

`default_nettype wire

//--- t07_branch_decoder.sv
`timescale 1ns/1ps
`default_nettype none

// looks at the fetched word and tells the program counter
// whether to jump, how far, and which comparison guards a branch
// purely combinational, zero latency
module t07_branch_decoder (
    input  rvIsaPkg::wordT instruction,
    output logic           forceJump,
    output logic           condJump,
    output logic [2:0]     func3,
    output rvIsaPkg::wordT JumpDist
);
    import rvIsaPkg::*;
    import fetchPkg::*;

    opcodeT   opcode;
    jumpKindT kind;
    logic     sign;
    wordT     jImm;
    wordT     bImm;

    // opcode field viewed through the enum
    assign opcode = opcodeT'(instruction[opcodeMsb:opcodeLsb]);

    // func3 goes straight through, the pc decides what it means
    assign func3 = instruction[func3Msb:func3Lsb];

    // jump kind from the opcode
    always_comb begin
        case (opcode)
            opJal:    kind = jumpForce;
            opBranch: kind = jumpCond;
            // jalr is not resolved here, pc-relative only
            // op, opImm, loads, stores, lui, auipc just step
            default:  kind = jumpNone;
        endcase
    end

    assign forceJump = (kind == jumpForce);
    assign condJump  = (kind == jumpCond);

    assign sign = instruction[signBit];

    // j-type immediate
    // imm[20|10:1|11|19:12] sits in bits 31:12, bit 0 always zero
    assign jImm = {
        {12{sign}},
        instruction[19:12],
        instruction[20],
        instruction[30:21],
        1'b0
    };

    // b-type immediate
    // imm[12|10:5] in bits 31:25, imm[4:1|11] in bits 11:7
    assign bImm = {
        {20{sign}},
        instruction[7],
        instruction[30:25],
        instruction[11:8],
        1'b0
    };

    // jump distance, zero when nothing jumps
    always_comb begin
        case (kind)
            jumpForce: JumpDist = jImm;
            jumpCond:  JumpDist = bImm;
            default:   JumpDist = '0;
        endcase
    end

    // the pc gives forceJump priority, so both high would hide a branch
    always_comb begin
        strobesExclusive: assert final (!(forceJump && condJump))
            else $error("decoder raised both jump strobes for %h", instruction);
    end

endmodule

`default_nettype wire

//--- t07_branch_flags.sv
`timescale 1ns/1ps
`default_nettype none

// condition flags for branch resolution
// compares the two operands both signed and unsigned
module t07_branch_flags (
    input  rvIsaPkg::wordT  operandA,
    input  rvIsaPkg::wordT  operandB,
    output fetchPkg::flagsT ALU_flags
);
    import fetchPkg::*;

    logic isEqual;
    logic isNotEqual;
    logic isLessSigned;
    logic isLessUnsigned;
    logic isZero;

    // equality does not care about signedness
    assign isEqual = (operandA == operandB);

    // any differing bit means the operands are not equal
    assign isNotEqual = |(operandA ^ operandB);

    // blt / bge view the operands as two's complement
    assign isLessSigned = ($signed(operandA) < $signed(operandB));

    // bltu / bgeu use the raw bit patterns
    assign isLessUnsigned = (operandA < operandB);

    // zero test on operand a that no branch reads
    assign isZero = (operandA == '0);

    // pack into the named positions
    // greater-or-equal is simply the complement of less-than
    always_comb begin
        ALU_flags           = '0;
        ALU_flags[eqFlag]   = isEqual;
        ALU_flags[neFlag]   = isNotEqual;
        ALU_flags[ltuFlag]  = isLessUnsigned;
        ALU_flags[ltFlag]   = isLessSigned;
        ALU_flags[geuFlag]  = !isLessUnsigned;
        ALU_flags[geFlag]   = !isLessSigned;
        ALU_flags[zeroFlag] = isZero;
    end

    // beq and bne read separate bits that must never agree
    always_comb begin
        eqNeComplement: assert final (ALU_flags[eqFlag] != ALU_flags[neFlag])
            else $error("eq and ne flags agree, a %h b %h", operandA, operandB);
    end

endmodule

`default_nettype wire

//--- t07_program_counter.sv
`timescale 1ns/1ps
`default_nettype none

// program counter and link register
// jal moves by JumpDist and links pc + 4
// a branch moves by JumpDist only when its flag is set, link stays 0
// everything else steps by one word
module t07_program_counter #(
    parameter rvIsaPkg::wordT resetVector = '0
) (
    input  logic            clk,
    input  logic            nrst,
    input  logic            freeze,
    input  logic            forceJump,
    input  logic            condJump,
    input  logic [2:0]      func3,
    input  fetchPkg::flagsT ALU_flags,
    input  rvIsaPkg::wordT  JumpDist,
    output rvIsaPkg::wordT  programCounter,
    output rvIsaPkg::wordT  linkAddress
);
    import rvIsaPkg::*;
    import fetchPkg::*;

    localparam wordT pcStep = wordT'(wordBytes);

    wordT nextPc;
    wordT nextLink;
    logic branchTaken;

    // pick the flag that guards this branch
    always_comb begin
        case (branchFunctT'(func3))
            funcBeq:  branchTaken = ALU_flags[eqFlag];
            funcBne:  branchTaken = ALU_flags[neFlag];
            funcBlt:  branchTaken = ALU_flags[ltFlag];
            funcBge:  branchTaken = ALU_flags[geFlag];
            funcBltu: branchTaken = ALU_flags[ltuFlag];
            funcBgeu: branchTaken = ALU_flags[geuFlag];
            // 010 and 011 fall through and never branch
            default:  branchTaken = 1'b0;
        endcase
    end

    // next-address selection
    always_comb begin
        nextPc   = programCounter + pcStep;
        nextLink = '0;
        if (freeze) begin
            // hold both registers
            nextPc   = programCounter;
            nextLink = linkAddress;
        end else if (forceJump) begin
            nextPc   = programCounter + JumpDist;
            nextLink = programCounter + pcStep;
        end else if (condJump && branchTaken) begin
            nextPc = programCounter + JumpDist;
        end
    end

    // state update, synchronous reset to the vector
    always_ff @(posedge clk) begin
        if (!nrst) begin
            programCounter <= resetVector;
            linkAddress    <= '0;
        end else begin
            programCounter <= nextPc;
            linkAddress    <= nextLink;
        end
    end

    // freeze is the only stall, nothing may slip through it
    freezeHolds: assert property (
        @(posedge clk) disable iff (!nrst)
        (nrst && freeze) |=> ($stable(programCounter) && $stable(linkAddress))
    ) else $error("pc or link moved under freeze, pc %h", programCounter);

endmodule

`default_nettype wire

//--- t07_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

// fetch and branch resolution slice
// memory -> decoder -> program counter, flags from the external operands
// single cycle, the fetched word follows the pc combinationally
module t07_fetch_unit #(
    parameter int             imemWords   = 256,
    parameter rvIsaPkg::wordT resetVector = '0
) (
    input  logic           clk,
    input  logic           nrst,
    input  logic           freeze,
    input  rvIsaPkg::wordT operandA,
    input  rvIsaPkg::wordT operandB,
    input  logic           loadEn,
    input  rvIsaPkg::wordT loadAddr,
    input  rvIsaPkg::wordT loadData,
    output rvIsaPkg::wordT programCounter,
    output rvIsaPkg::wordT linkAddress,
    output rvIsaPkg::wordT instruction
);
    import rvIsaPkg::*;
    import fetchPkg::*;

    // decoder to pc
    logic       forceJump;
    logic       condJump;
    logic [2:0] func3;
    wordT       JumpDist;

    // comparator to pc
    flagsT ALU_flags;

    // instruction store, read at the current pc
    t07_instruction_memory #(
        .imemWords(imemWords)
    ) imem (
        .clk     (clk),
        .loadEn  (loadEn),
        .loadAddr(loadAddr),
        .loadData(loadData),
        .readAddr(programCounter),
        .readData(instruction)
    );

    t07_branch_decoder decoder (
        .instruction(instruction),
        .forceJump  (forceJump),
        .condJump   (condJump),
        .func3      (func3),
        .JumpDist   (JumpDist)
    );

    // operands stand in for register file reads
    t07_branch_flags flags (
        .operandA (operandA),
        .operandB (operandB),
        .ALU_flags(ALU_flags)
    );

    t07_program_counter #(
        .resetVector(resetVector)
    ) pc (
        .clk           (clk),
        .nrst          (nrst),
        .freeze        (freeze),
        .forceJump     (forceJump),
        .condJump      (condJump),
        .func3         (func3),
        .ALU_flags     (ALU_flags),
        .JumpDist      (JumpDist),
        .programCounter(programCounter),
        .linkAddress   (linkAddress)
    );

endmodule

`default_nettype wire

//--- tb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

// directed testbench for the fetch and branch resolution slice
// inputs change just after the rising edge and outputs are checked on the falling edge
module tb_fetch_unit;
    import rvIsaPkg::*;
    import fetchPkg::*;

    localparam int   memDepth   = 64;
    localparam wordT bootVector = 32'h0000_0000;
    // fill takes 65 cycles, reset and plain 14, jal and freeze 31 and each of eight codes 45
    // which comes to 470 cycles and leaves the limit plenty of margin
    localparam int   maxCycles  = 2000;

    logic clk;
    logic nrst;
    logic freeze;
    logic loadEn;
    wordT operandA;
    wordT operandB;
    wordT loadAddr;
    wordT loadData;
    wordT programCounter;
    wordT linkAddress;
    wordT instruction;

    // shadow of the memory contents, the jump distance and the opcode of every word
    wordT   memWords [memDepth];
    wordT   memOffsets [memDepth];
    opcodeT memOpcodes [memDepth];
    // program under construction that the loader writes out
    wordT   progWords [$];
    wordT   progOffsets [$];
    opcodeT progOpcodes [$];

    // where the pc and link register should be after the last edge
    wordT   expPc;
    wordT   expLink;
    int     errorCount = 0;
    int     checkCount = 0;
    int     cycleCount = 0;
    integer seed = 32'h83a9_81d3;

    t07_fetch_unit #(
        .imemWords  (memDepth),
        .resetVector(bootVector)
    ) dut (
        .clk           (clk),
        .nrst          (nrst),
        .freeze        (freeze),
        .operandA      (operandA),
        .operandB      (operandB),
        .loadEn        (loadEn),
        .loadAddr      (loadAddr),
        .loadData      (loadData),
        .programCounter(programCounter),
        .linkAddress   (linkAddress),
        .instruction   (instruction)
    );

    always begin
        #5 clk = ~clk;
    end

    // run length guard
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= maxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", maxCycles);
            $display("Simulation failed");
            $finish;
        end
    end

    // addi rd, x0, imm
    function automatic wordT encodeAddi(input logic [4:0] rd, input logic [11:0] imm);
        return {imm, 5'd0, 3'b000, rd, opOpImm};
    endfunction

    // jal rd, offset
    function automatic wordT encodeJal(input logic [4:0] rd, input wordT offset);
        return {offset[20], offset[10:1], offset[11], offset[19:12], rd, opJal};
    endfunction

    // branch on x1 against x2 with the comparison picked by f3
    function automatic wordT encodeBranch(input logic [2:0] f3, input wordT offset);
        return {offset[12], offset[10:5], 5'd2, 5'd1, f3, offset[4:1], offset[11], opBranch};
    endfunction

    function automatic wordT randomWord();
        return wordT'($random(seed));
    endfunction

    task automatic pushWord(input wordT word, input wordT offset, input opcodeT op);
        progWords.push_back(word);
        progOffsets.push_back(offset);
        progOpcodes.push_back(op);
    endtask

    // writes the queued program from base on while freeze holds the pc
    task automatic loadProgram(input wordT base);
        int i;
        int idx;
        freeze <= 1'b1;
        for (i = 0; i < progWords.size(); i++) begin
            idx = int'(((base >> 2) + wordT'(i)) % memDepth);
            loadEn   <= 1'b1;
            loadAddr <= base + wordT'(4 * i);
            loadData <= progWords[i];
            memWords[idx]   = progWords[i];
            memOffsets[idx] = progOffsets[i];
            memOpcodes[idx] = progOpcodes[i];
            @(posedge clk);
        end
        loadEn <= 1'b0;
        progWords.delete();
        progOffsets.delete();
        progOpcodes.delete();
    endtask

    // every word an addi whose immediate mixes in its own address
    task automatic fillMemory;
        int i;
        for (i = 0; i < memDepth; i++) begin
            pushWord(encodeAddi(5'(i), 12'(i * 4) ^ 12'h3c1), '0, opOpImm);
        end
        loadProgram('0);
    endtask

    // two edges with nrst low
    task automatic applyReset;
        nrst <= 1'b0;
        repeat (2) @(posedge clk);
        nrst <= 1'b1;
        expPc   = bootVector;
        expLink = '0;
    endtask

    task automatic checkWord(input string name, input wordT actual, input wordT expected);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s: got %h, expected %h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic checkInstruction(input wordT actual, input wordT expWord, input opcodeT expOp);
        opcodeT gotOp;
        gotOp = opcodeT'(actual[6:0]);
        checkCount++;
        if (actual !== expWord || gotOp !== expOp) begin
            errorCount++;
            $display("[ERROR] instruction: got %h (opcode %h), expected %h (opcode %h) at %0t",
                     actual, gotOp, expWord, expOp, $time);
        end
    endtask

    task automatic checkState;
        int idx;
        idx = int'((expPc >> 2) % memDepth);
        checkWord("programCounter", programCounter, expPc);
        checkWord("linkAddress", linkAddress, expLink);
        checkInstruction(instruction, memWords[idx], memOpcodes[idx]);
    endtask

    // jal always moves and links while a branch moves only when its compare holds
    task automatic predictNext(input wordT pc, input wordT a, input wordT b,
                               output wordT nextPc, output wordT nextLink);
        int       idx;
        wordT     word;
        jumpKindT kind;
        logic     holds;
        idx  = int'((pc >> 2) % memDepth);
        word = memWords[idx];
        case (memOpcodes[idx])
            opJal:    kind = jumpForce;
            opBranch: kind = jumpCond;
            default:  kind = jumpNone;
        endcase
        case (branchFunctT'(word[14:12]))
            funcBeq:  holds = (a == b);
            funcBne:  holds = (a != b);
            funcBlt:  holds = ($signed(a) < $signed(b));
            funcBge:  holds = ($signed(a) >= $signed(b));
            funcBltu: holds = (a < b);
            funcBgeu: holds = (a >= b);
            // 010 and 011 have no comparison
            default:  holds = 1'b0;
        endcase
        nextPc   = pc + 32'd4;
        nextLink = '0;
        if (kind == jumpForce) begin
            nextPc   = pc + memOffsets[idx];
            nextLink = pc + 32'd4;
        end else if (kind == jumpCond && holds) begin
            nextPc = pc + memOffsets[idx];
        end
    endtask

    // check the state left by the last edge and then predict the next one
    task automatic observeCycle;
        wordT nextPc;
        wordT nextLink;
        @(negedge clk);
        checkState();
        if (freeze) begin
            nextPc   = expPc;
            nextLink = expLink;
        end else begin
            predictNext(expPc, operandA, operandB, nextPc, nextLink);
        end
        @(posedge clk);
        expPc   = nextPc;
        expLink = nextLink;
    endtask

    task automatic stepCheck(input logic frz, input wordT a, input wordT b);
        freeze   <= frz;
        operandA <= a;
        operandB <= b;
        observeCycle();
    endtask

    task automatic testReset;
        applyReset();
        // a held step checks the vector, the zero link and word 0
        stepCheck(1'b1, '0, '0);
    endtask

    task automatic testPlain;
        applyReset();
        repeat (8) stepCheck(1'b0, randomWord(), randomWord());
        observeCycle();
    endtask

    // jal forward at 24 to 40 and jal back at 40 to 20
    task automatic testJal;
        pushWord(encodeJal(5'd1, 32'd16), 32'd16, opJal);
        loadProgram(32'd24);
        pushWord(encodeJal(5'd1, wordT'(-20)), wordT'(-20), opJal);
        loadProgram(32'd40);
        applyReset();
        repeat (9) stepCheck(1'b0, randomWord(), randomWord());
        observeCycle();
    endtask

    task automatic testFreeze;
        applyReset();
        // stop on the backward jal with a live link value
        repeat (7) stepCheck(1'b0, randomWord(), randomWord());
        repeat (4) stepCheck(1'b1, randomWord(), randomWord());
        repeat (3) stepCheck(1'b0, randomWord(), randomWord());
        observeCycle();
    endtask

    task automatic branchCase(input wordT a, input wordT b);
        applyReset();
        stepCheck(1'b0, a, b);
        observeCycle();
    endtask

    // one branch at address 0 where odd codes jump backwards
    task automatic runBranchCode(input logic [2:0] f3);
        wordT offset;
        wordT a;
        int   i;
        offset = f3[0] ? wordT'(-8) : wordT'(16);
        pushWord(encodeBranch(f3, offset), offset, opBranch);
        loadProgram('0);
        for (i = 0; i < 6; i++) begin
            branchCase(randomWord(), randomWord());
        end
        a = randomWord();
        branchCase(a, a);
        // sign boundary and all ones against zero
        branchCase(32'h7fff_ffff, 32'h8000_0000);
        branchCase(32'h8000_0000, 32'h7fff_ffff);
        branchCase(32'h0000_0000, 32'hffff_ffff);
        branchCase(32'hffff_ffff, 32'h0000_0000);
    endtask

    task automatic testBranches;
        runBranchCode(funcBeq);
        runBranchCode(funcBne);
        runBranchCode(funcBlt);
        runBranchCode(funcBge);
        runBranchCode(funcBltu);
        runBranchCode(funcBgeu);
    endtask

    task automatic testUnusedCodes;
        runBranchCode(3'b010);
        runBranchCode(3'b011);
    endtask

    initial begin
        clk      = 1'b0;
        nrst     = 1'b0;
        freeze   = 1'b1;
        loadEn   = 1'b0;
        loadAddr = '0;
        loadData = '0;
        operandA = '0;
        operandB = '0;
        @(posedge clk);
        fillMemory();
        testReset();
        testPlain();
        testJal();
        testFreeze();
        testBranches();
        testUnusedCodes();
        $display("checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
rvIsaPkg.sv
fetchPkg.sv
t07_instruction_memory.sv
t07_branch_decoder.sv
t07_branch_flags.sv
t07_program_counter.sv
t07_fetch_unit.sv
tb_fetch_unit.sv

//--- Makefile
TOP = tb_fetch_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir
